// ==== design/main_pkg.sv ====
`default_nettype none

package main_pkg;

    // any opcode not named here is a no-op
    typedef logic [5:0] op_t;

    localparam op_t OP_FORK = 6'h38;
    localparam op_t OP_JOIN = 6'h39;
    localparam op_t OP_IN   = 6'h3a;
    localparam op_t OP_OUT  = 6'h3b;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  count_t;

    typedef enum logic [2:0] {
        RUN_ST,
        JOINING_ST,
        PRE_READ_ST,
        READ_ST,
        PRE_WRITE_ST,
        WRITE_ST
    } ctrl_state_t;

    localparam int DEF_SUBCORE_NUM  = 8;
    localparam int DEF_CLKS_PER_BIT = 434;

    // index or counter width of at least one bit
    function automatic int bits_for(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire

// ==== design/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx import main_pkg::*; #(
    parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  rx,
    input  logic  arm,
    output byte_t data,
    output logic  done
);

    localparam int CNT_W = bits_for(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF     = CNT_W'(CLKS_PER_BIT / 2);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             armed;
    logic             active;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    byte_t            shreg;
    logic             sample;

    // start bit checked at its middle and later bits one period apart
    assign sample = active && ((bit_cnt == 4'd0) ? (clk_cnt == HALF) : (clk_cnt == BIT_LAST));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            armed   <= 1'b0;
            active  <= 1'b0;
            done    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= 4'd0;
        end else begin
            done <= 1'b0;
            if (!armed) begin
                armed <= arm;
            end else if (!active) begin
                // wait for a falling edge
                if (rx_prev && !rx_sync) begin
                    active  <= 1'b1;
                    clk_cnt <= '0;
                    bit_cnt <= 4'd0;
                end
            end else if (sample) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd0 && rx_sync) begin
                    // glitch rather than a start bit
                    active <= 1'b0;
                end else if (bit_cnt == 4'd9) begin
                    active <= 1'b0;
                    armed  <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (sample && bit_cnt == 4'd9) begin
            data <= shreg;
        end
    end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx import main_pkg::*; #(
    parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  start,
    input  byte_t data,
    output logic  busy,
    output logic  done,
    output logic  tx
);

    localparam int CNT_W = bits_for(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [8:0]       shreg;
    logic             bit_end;

    assign bit_end = busy && (clk_cnt == BIT_LAST);

    // bit_cnt 0 is the start bit and 9 the stop bit
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            tx      <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= 4'd0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy    <= 1'b1;
                    tx      <= 1'b0;
                    clk_cnt <= '0;
                    bit_cnt <= 4'd0;
                end
            end else if (bit_end) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    tx      <= shreg[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end
        end
    end

    // data lsb first with the stop bit behind it
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            shreg <= {1'b1, data};
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

`default_nettype wire

// ==== design/subcore_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module subcore_tracker import main_pkg::*; #(
    parameter int SUBCORE_NUM = DEF_SUBCORE_NUM,
    localparam int IDX_W = bits_for(SUBCORE_NUM)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   fork_fire,
    input  logic [IDX_W-1:0]       fork_target,
    input  word_t                  fork_pc,
    input  logic                   join_done,
    output logic [SUBCORE_NUM-1:0] exec_requested,
    output word_t                  requested_pc,
    output count_t                 living_sub_count
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            exec_requested   <= '0;
            living_sub_count <= '0;
        end else begin
            // one-cycle start request
            for (int i = 0; i < SUBCORE_NUM; i++) begin
                exec_requested[i] <= fork_fire && (fork_target == IDX_W'(i));
            end
            if (fork_fire && !join_done) begin
                living_sub_count <= living_sub_count + count_t'(1);
            end else if (join_done && !fork_fire) begin
                living_sub_count <= living_sub_count - count_t'(1);
            end
        end
    end

    // start address shared by all subcores
    always_ff @(posedge clk) begin
        if (fork_fire) begin
            requested_pc <= fork_pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/issue_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_ctrl import main_pkg::*; #(
    parameter int SUBCORE_NUM = DEF_SUBCORE_NUM,
    localparam int IDX_W = bits_for(SUBCORE_NUM)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   inst_valid,
    input  op_t                    inst_op,
    input  word_t                  inst_srca,
    input  word_t                  inst_srcb,
    input  byte_t                  inst_wdata,
    input  logic [SUBCORE_NUM-1:0] subcore_ended,
    output logic                   interlock,
    output byte_t                  in_data,
    output logic                   fork_fire,
    output logic                   join_done,
    output logic [IDX_W-1:0]       fork_target,
    output word_t                  fork_pc,
    output logic                   rx_arm,
    input  byte_t                  rx_data,
    input  logic                   rx_done,
    output logic                   tx_start,
    output byte_t                  tx_data,
    input  logic                   tx_busy,
    input  logic                   tx_done
);

    ctrl_state_t      state;
    logic [IDX_W-1:0] join_target;
    logic             accept;

    assign accept      = inst_valid && !interlock;
    assign fork_fire   = accept && (inst_op == OP_FORK);
    assign fork_target = inst_srca[IDX_W-1:0];
    assign fork_pc     = inst_srcb;
    assign join_done   = (state == JOINING_ST) && subcore_ended[join_target];

    // ==================
    // state machine
    // ==================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= RUN_ST;
            interlock <= 1'b0;
            rx_arm    <= 1'b0;
            tx_start  <= 1'b0;
        end else begin
            rx_arm   <= 1'b0;
            tx_start <= 1'b0;
            case (state)
                RUN_ST: begin
                    if (accept) begin
                        case (inst_op)
                            OP_JOIN: begin
                                interlock <= 1'b1;
                                state     <= JOINING_ST;
                            end
                            OP_IN: begin
                                interlock <= 1'b1;
                                state     <= PRE_READ_ST;
                            end
                            OP_OUT: begin
                                interlock <= 1'b1;
                                state     <= PRE_WRITE_ST;
                            end
                            // fork and no-ops pass straight through
                            default: ;
                        endcase
                    end
                end
                JOINING_ST: begin
                    if (join_done) begin
                        interlock <= 1'b0;
                        state     <= RUN_ST;
                    end
                end
                PRE_READ_ST: begin
                    rx_arm <= 1'b1;
                    state  <= READ_ST;
                end
                READ_ST: begin
                    if (rx_done) begin
                        interlock <= 1'b0;
                        state     <= RUN_ST;
                    end
                end
                PRE_WRITE_ST: begin
                    // previous frame may still be on the line
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        state    <= WRITE_ST;
                    end
                end
                WRITE_ST: begin
                    if (tx_done) begin
                        interlock <= 1'b0;
                        state     <= RUN_ST;
                    end
                end
                default: state <= RUN_ST;
            endcase
        end
    end

    // ==================
    // operand latches
    // ==================
    always_ff @(posedge clk) begin
        if (accept && inst_op == OP_JOIN) begin
            join_target <= inst_srca[IDX_W-1:0];
        end
        if (accept && inst_op == OP_OUT) begin
            tx_data <= inst_wdata;
        end
        if (state == READ_ST && rx_done) begin
            in_data <= rx_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/main_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module main_ctrl import main_pkg::*; #(
    parameter int SUBCORE_NUM  = DEF_SUBCORE_NUM,
    parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT,
    localparam int IDX_W = bits_for(SUBCORE_NUM)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   inst_valid,
    input  op_t                    inst_op,
    input  word_t                  inst_srca,
    input  word_t                  inst_srcb,
    input  byte_t                  inst_wdata,
    output logic                   interlock,
    output byte_t                  in_data,
    input  logic [SUBCORE_NUM-1:0] subcore_ended,
    output logic [SUBCORE_NUM-1:0] exec_requested,
    output word_t                  requested_pc,
    output count_t                 living_sub_count,
    input  logic                   rx,
    output logic                   tx
);

    logic             fork_fire;
    logic [IDX_W-1:0] fork_target;
    word_t            fork_pc;
    logic             join_done;

    logic             rx_arm;
    byte_t            rx_data;
    logic             rx_done;

    logic             tx_start;
    byte_t            tx_data;
    logic             tx_busy;
    logic             tx_done;

    issue_ctrl #(
        .SUBCORE_NUM(SUBCORE_NUM)
    ) issue_ctrl_inst (
        .clk(clk),
        .rstn(rstn),
        .inst_valid(inst_valid),
        .inst_op(inst_op),
        .inst_srca(inst_srca),
        .inst_srcb(inst_srcb),
        .inst_wdata(inst_wdata),
        .subcore_ended(subcore_ended),
        .interlock(interlock),
        .in_data(in_data),
        .fork_fire(fork_fire),
        .join_done(join_done),
        .fork_target(fork_target),
        .fork_pc(fork_pc),
        .rx_arm(rx_arm),
        .rx_data(rx_data),
        .rx_done(rx_done),
        .tx_start(tx_start),
        .tx_data(tx_data),
        .tx_busy(tx_busy),
        .tx_done(tx_done)
    );

    subcore_tracker #(
        .SUBCORE_NUM(SUBCORE_NUM)
    ) subcore_tracker_inst (
        .clk(clk),
        .rstn(rstn),
        .fork_fire(fork_fire),
        .fork_target(fork_target),
        .fork_pc(fork_pc),
        .join_done(join_done),
        .exec_requested(exec_requested),
        .requested_pc(requested_pc),
        .living_sub_count(living_sub_count)
    );

    // ==================
    // uart
    // ==================
    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_rx_inst (
        .clk(clk),
        .rstn(rstn),
        .rx(rx),
        .arm(rx_arm),
        .data(rx_data),
        .done(rx_done)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_tx_inst (
        .clk(clk),
        .rstn(rstn),
        .start(tx_start),
        .data(tx_data),
        .busy(tx_busy),
        .done(tx_done),
        .tx(tx)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release away from the sampling edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_main_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_main_ctrl import main_pkg::*; ();

    localparam int SUBCORE_NUM    = 8;
    localparam int CLKS_PER_BIT   = 4;
    localparam int IDX_W          = $clog2(SUBCORE_NUM);
    localparam int TIMEOUT_CYCLES = 200;

    logic                   clk;
    logic                   rstn;
    logic                   inst_valid;
    op_t                    inst_op;
    word_t                  inst_srca;
    word_t                  inst_srcb;
    byte_t                  inst_wdata;
    logic                   interlock;
    byte_t                  in_data;
    logic [SUBCORE_NUM-1:0] subcore_ended;
    logic [SUBCORE_NUM-1:0] exec_requested;
    word_t                  requested_pc;
    count_t                 living_sub_count;
    logic                   rx;
    logic                   tx;

    integer seed;
    int     err_count;
    int     timeout_count;
    count_t exp_count;

    tb_clock #(
        .PERIOD(40),
        .RESET_CYCLES(8)
    ) clock_inst (
        .clk(clk),
        .rstn(rstn)
    );

    main_ctrl #(
        .SUBCORE_NUM(SUBCORE_NUM),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) main_ctrl_inst (
        .clk(clk),
        .rstn(rstn),
        .inst_valid(inst_valid),
        .inst_op(inst_op),
        .inst_srca(inst_srca),
        .inst_srcb(inst_srcb),
        .inst_wdata(inst_wdata),
        .interlock(interlock),
        .in_data(in_data),
        .subcore_ended(subcore_ended),
        .exec_requested(exec_requested),
        .requested_pc(requested_pc),
        .living_sub_count(living_sub_count),
        .rx(rx),
        .tx(tx)
    );

    // ====================
    // compare tasks
    // ====================
    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic compare_count(input string name, input count_t expected,
                                 input count_t actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timed out waiting for %s at %0t", what, $time);
    endtask

    // ====================
    // drivers and waits
    // ====================
    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rstn !== 1'b1 && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (rstn !== 1'b1) report_timeout("reset release");
        @(negedge clk);
    endtask

    task automatic wait_interlock_low(input string what);
        int n;
        n = 0;
        while (interlock !== 1'b0 && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (interlock !== 1'b0) report_timeout(what);
    endtask

    // called on a falling edge and returns on the one after acceptance
    task automatic issue(input op_t op, input word_t srca, input word_t srcb, input byte_t wdata);
        inst_valid = 1'b1;
        inst_op    = op;
        inst_srca  = srca;
        inst_srcb  = srcb;
        inst_wdata = wdata;
        wait_interlock_low("interlock to drop before issue");
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic send_bit(input logic value);
        rx = value;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_frame(input byte_t value);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(value[i]);
        end
        send_bit(1'b1);
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_reset();
        compare_bit("interlock", 1'b0, interlock);
        for (int i = 0; i < SUBCORE_NUM; i++) begin
            compare_bit($sformatf("exec_requested[%0d]", i), 1'b0, exec_requested[i]);
        end
        compare_count("living_sub_count", 4'd0, living_sub_count);
        compare_bit("tx", 1'b1, tx);
    endtask

    task automatic test_fork();
        word_t r;
        word_t pc;
        int    t;
        for (int k = 0; k < 3; k++) begin
            r  = $random(seed);
            pc = $random(seed);
            t  = int'(r[IDX_W-1:0]);
            issue(OP_FORK, r, pc, 8'h00);
            exp_count = exp_count + 4'd1;
            for (int i = 0; i < SUBCORE_NUM; i++) begin
                compare_bit($sformatf("exec_requested[%0d]", i), (i == t), exec_requested[i]);
            end
            compare_word("requested_pc", pc, requested_pc);
            compare_count("living_sub_count", exp_count, living_sub_count);
            compare_bit("interlock", 1'b0, interlock);
            // request lasts one cycle only
            @(negedge clk);
            for (int i = 0; i < SUBCORE_NUM; i++) begin
                compare_bit($sformatf("exec_requested[%0d]", i), 1'b0, exec_requested[i]);
            end
        end
        compare_count("living_sub_count", 4'd3, living_sub_count);
    endtask

    task automatic test_join();
        word_t r;
        int    t;
        r = $random(seed);
        t = int'(r[IDX_W-1:0]);
        // every other subcore already ended
        subcore_ended = ~(SUBCORE_NUM'(1) << t);
        issue(OP_JOIN, r, 32'h0, 8'h00);
        for (int n = 0; n < 20; n++) begin
            compare_bit("interlock", 1'b1, interlock);
            compare_count("living_sub_count", exp_count, living_sub_count);
            @(negedge clk);
        end
        subcore_ended[t] = 1'b1;
        wait_interlock_low("join completion");
        exp_count = exp_count - 4'd1;
        compare_count("living_sub_count", exp_count, living_sub_count);
        subcore_ended = '0;
        @(negedge clk);
    endtask

    task automatic test_out();
        word_t r;
        byte_t value;
        byte_t got;
        int    n;
        r     = $random(seed);
        value = r[7:0];
        got   = 8'h00;
        issue(OP_OUT, 32'h0, 32'h0, value);
        compare_bit("interlock", 1'b1, interlock);
        n = 0;
        while (tx && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (tx) begin
            report_timeout("start bit on tx");
            return;
        end
        // middle of the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        compare_bit("tx start bit", 1'b0, tx);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            got[i] = tx;
            compare_bit("interlock", 1'b1, interlock);
        end
        compare_byte("tx data", value, got);
        repeat (CLKS_PER_BIT) @(negedge clk);
        compare_bit("tx stop bit", 1'b1, tx);
        wait_interlock_low("end of out");
    endtask

    task automatic test_in();
        word_t r;
        byte_t value;
        r     = $random(seed);
        value = r[7:0];
        // receiver not armed yet
        send_frame(~value);
        issue(OP_IN, 32'h0, 32'h0, 8'h00);
        for (int n = 0; n < 10; n++) begin
            compare_bit("interlock", 1'b1, interlock);
            @(negedge clk);
        end
        send_frame(value);
        wait_interlock_low("end of in");
        compare_byte("in_data", value, in_data);
    endtask

    initial begin
        seed          = 32'hba7b677b;
        err_count     = 0;
        timeout_count = 0;
        exp_count     = 4'd0;
        inst_valid    = 1'b0;
        inst_op       = 6'h00;
        inst_srca     = 32'h0;
        inst_srcb     = 32'h0;
        inst_wdata    = 8'h00;
        subcore_ended = '0;
        rx            = 1'b1;

        wait_reset_release();
        test_reset();
        test_fork();
        test_join();
        test_out();
        test_in();

        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/main_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/subcore_tracker.sv
design/issue_ctrl.sv
design/main_ctrl.sv
verif/tb_clock.sv
verif/tb_main_ctrl.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_main_ctrl -f list.f -o sim_main_ctrl

out=$(./obj_dir/sim_main_ctrl)
echo "$out"

# fails the script when the pass line is missing
echo "$out" | grep -q "^Verification passed$"
